// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gfx_wbs
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator and run $(TOP), fails unless the pass line is printed"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
+incdir+hdl
hdl/gfx_reg_pkg.sv
hdl/gfx_ctrl_pkg.sv
hdl/gfx_wr_if.sv
hdl/gfx_wb_slave.sv
hdl/gfx_instr_fifo.sv
hdl/gfx_reg_file.sv
hdl/gfx_cmd_sequencer.sv
hdl/gfx_wbs_top.sv
testbench/tb_gfx_wbs.sv

// File: hdl/gfx_cmd_sequencer.sv
module gfx_cmd_sequencer
(
  input  logic                         wbs_clk_i,
  input  logic                         rst_i,
  input  gfx_ctrl_pkg::gfx_draw_cmd_e  draw_cmd_i,
  input  logic                         cmd_active_i,
  input  logic                         pipeline_ack_i,
  output logic                         drain_ready_o,
  output logic                         busy_o,
  input  logic                         writer_sint_i,
  input  logic                         reader_sint_i,
  output logic                         inta_o
);

  import gfx_ctrl_pkg::*;

  gfx_seq_state_e state;

  always_ff @(posedge wbs_clk_i)
  begin
    if (rst_i)
      state <= IDLE;
    else
    begin
      case (state)
        IDLE:
        begin
          if (draw_cmd_i != NONE)
            state <= BUSY;
        end
        BUSY:
        begin
          // pipeline finished the operation
          if (pipeline_ack_i)
            state <= IDLE;
        end
      endcase
    end
  end

  assign busy_o = (state == BUSY);

  // no drain while a draw bit is still pending,
  // that keeps the queue behind the command
  assign drain_ready_o = (state == IDLE) & ~cmd_active_i;

  always_ff @(posedge wbs_clk_i)
  begin
    if (rst_i)
      inta_o <= 1'b0;
    else
      inta_o <= writer_sint_i | reader_sint_i;
  end

endmodule

// File: hdl/gfx_ctrl_pkg.sv
package gfx_ctrl_pkg;

  // front end sequencer states
  typedef enum logic
  {
    IDLE = 1'b0,
    BUSY = 1'b1
  } gfx_seq_state_e;

  // draw command sent to the pipeline
  typedef enum logic [1:0]
  {
    NONE  = 2'd0,
    RECT  = 2'd1,
    LINE  = 2'd2,
    POINT = 2'd3
  } gfx_draw_cmd_e;

endpackage

// File: hdl/gfx_defs.svh
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// bus and register width
`define GFX_DATA_W 32

// byte address of a register, bits 1:0 are never decoded
`define GFX_ADR_W 8

// log2 of the instruction fifo depth
`define GFX_FIFO_AW 4

// register reset values
`define GFX_CTRL_RESET 32'h0000_0001
`define GFX_ALPHA_RESET 32'hffff_ffff

`endif

// File: hdl/gfx_instr_fifo.sv
`include "gfx_defs.svh"

module gfx_instr_fifo
#(
  parameter int ADDR_W = `GFX_FIFO_AW
)
(
  input  logic            wbs_clk_i,
  input  logic            rst_i,
  gfx_wr_if.snk           enq,
  gfx_wr_if.src           deq,
  output logic [ADDR_W:0] count_o
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [`GFX_ADR_W-1:0]  adr_mem [DEPTH];
  logic [`GFX_DATA_W-1:0] dat_mem [DEPTH];
  logic [ADDR_W-1:0]      wr_ptr;
  logic [ADDR_W-1:0]      rd_ptr;
  logic                   push;
  logic                   pop;

  // ready means not full, valid means not empty
  assign enq.ready = (count_o != (ADDR_W+1)'(DEPTH));
  assign deq.valid = (count_o != '0);

  assign push = enq.valid & enq.ready;
  assign pop  = deq.valid & deq.ready;

  // front of the queue
  assign deq.adr = adr_mem[rd_ptr];
  assign deq.dat = dat_mem[rd_ptr];

  always_ff @(posedge wbs_clk_i)
  begin
    if (push)
    begin
      adr_mem[wr_ptr] <= enq.adr;
      dat_mem[wr_ptr] <= enq.dat;
    end
  end

  // pointers wrap on their own
  always_ff @(posedge wbs_clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

// File: hdl/gfx_reg_file.sv
`include "gfx_defs.svh"

module gfx_reg_file
(
  input  logic                                    wbs_clk_i,
  input  logic                                    rst_i,
  gfx_wr_if.snk                                   deq,
  input  gfx_reg_pkg::gfx_reg_e                   rd_adr_i,
  output logic [`GFX_DATA_W-1:0]                  rd_dat_o,
  input  logic                                    busy_i,
  input  logic [`GFX_FIFO_AW:0]                   fifo_count_i,
  output logic                                    cmd_active_o,
  output gfx_ctrl_pkg::gfx_draw_cmd_e             draw_cmd_o,
  output logic [`GFX_DATA_W-1:0]                  target_base_o,
  output logic [gfx_reg_pkg::POINT_W-1:0]         target_size_x_o,
  output logic [gfx_reg_pkg::POINT_W-1:0]         target_size_y_o,
  output logic [`GFX_DATA_W-1:0]                  dest_x_o,
  output logic [`GFX_DATA_W-1:0]                  dest_y_o,
  output logic [`GFX_DATA_W-1:0]                  color0_o,
  output logic [7:0]                              global_alpha_o,
  output logic [gfx_reg_pkg::CTRL_DEPTH_W-1:0]    color_depth_o,
  output logic                                    blending_enable_o
);

  import gfx_reg_pkg::*;
  import gfx_ctrl_pkg::*;

  logic [`GFX_DATA_W-1:0] control_reg;
  logic [`GFX_DATA_W-1:0] target_base_reg;
  logic [`GFX_DATA_W-1:0] target_size_x_reg;
  logic [`GFX_DATA_W-1:0] target_size_y_reg;
  logic [`GFX_DATA_W-1:0] dest_x_reg;
  logic [`GFX_DATA_W-1:0] dest_y_reg;
  logic [`GFX_DATA_W-1:0] color0_reg;
  logic [`GFX_DATA_W-1:0] alpha_reg;
  gfx_status_t            status;

  // ready comes from the sequencer, not from this block
  always_ff @(posedge wbs_clk_i)
  begin
    if (rst_i)
    begin
      control_reg       <= `GFX_CTRL_RESET;
      target_base_reg   <= '0;
      target_size_x_reg <= '0;
      target_size_y_reg <= '0;
      dest_x_reg        <= '0;
      dest_y_reg        <= '0;
      color0_reg        <= '0;
      alpha_reg         <= `GFX_ALPHA_RESET;
    end
    else
    begin
      // draw bits only live for one cycle
      control_reg[CTRL_POINT_BIT:CTRL_RECT_BIT] <= '0;
      if (deq.valid & deq.ready)
      begin
        case (deq.adr)
          CONTROL:       control_reg       <= deq.dat;
          TARGET_BASE:   target_base_reg   <= deq.dat;
          TARGET_SIZE_X: target_size_x_reg <= deq.dat;
          TARGET_SIZE_Y: target_size_y_reg <= deq.dat;
          DEST_X:        dest_x_reg        <= deq.dat;
          DEST_Y:        dest_y_reg        <= deq.dat;
          COLOR0:        color0_reg        <= deq.dat;
          ALPHA:         alpha_reg         <= deq.dat;
          // status and unmapped addresses are dropped
          default:       ;
        endcase
      end
    end
  end

  assign cmd_active_o = |control_reg[CTRL_POINT_BIT:CTRL_RECT_BIT];

  // lowest draw bit wins
  always_comb
  begin
    if (control_reg[CTRL_RECT_BIT])
      draw_cmd_o = RECT;
    else if (control_reg[CTRL_LINE_BIT])
      draw_cmd_o = LINE;
    else if (control_reg[CTRL_POINT_BIT])
      draw_cmd_o = POINT;
    else
      draw_cmd_o = NONE;
  end

  always_comb
  begin
    status          = '0;
    status.busy     = busy_i;
    status.count    = 16'(fifo_count_i);
  end

  // read mux, queued writes are not visible here
  always_comb
  begin
    case (rd_adr_i)
      CONTROL:       rd_dat_o = control_reg;
      STATUS:        rd_dat_o = status;
      TARGET_BASE:   rd_dat_o = target_base_reg;
      TARGET_SIZE_X: rd_dat_o = target_size_x_reg;
      TARGET_SIZE_Y: rd_dat_o = target_size_y_reg;
      DEST_X:        rd_dat_o = dest_x_reg;
      DEST_Y:        rd_dat_o = dest_y_reg;
      COLOR0:        rd_dat_o = color0_reg;
      ALPHA:         rd_dat_o = alpha_reg;
      default:       rd_dat_o = '0;
    endcase
  end

  // field outputs
  assign target_base_o     = target_base_reg;
  assign target_size_x_o   = target_size_x_reg[POINT_W-1:0];
  assign target_size_y_o   = target_size_y_reg[POINT_W-1:0];
  assign dest_x_o          = dest_x_reg;
  assign dest_y_o          = dest_y_reg;
  assign color0_o          = color0_reg;
  assign global_alpha_o    = alpha_reg[7:0];
  assign color_depth_o     = control_reg[CTRL_DEPTH_LSB +: CTRL_DEPTH_W];
  assign blending_enable_o = control_reg[CTRL_BLEND_BIT];

endmodule

// File: hdl/gfx_reg_pkg.sv
`include "gfx_defs.svh"

package gfx_reg_pkg;

  // register byte addresses
  typedef enum logic [`GFX_ADR_W-1:0]
  {
    CONTROL       = 8'h00,
    STATUS        = 8'h04,
    TARGET_BASE   = 8'h08,
    TARGET_SIZE_X = 8'h0C,
    TARGET_SIZE_Y = 8'h10,
    DEST_X        = 8'h14,
    DEST_Y        = 8'h18,
    COLOR0        = 8'h1C,
    ALPHA         = 8'h20
  } gfx_reg_e;

  // width of target sizes
  localparam int POINT_W = 16;

  // control register fields
  localparam int CTRL_DEPTH_LSB = 0;
  localparam int CTRL_DEPTH_W   = 2;
  localparam int CTRL_BLEND_BIT = 2;
  localparam int CTRL_RECT_BIT  = 8;
  localparam int CTRL_LINE_BIT  = 9;
  localparam int CTRL_POINT_BIT = 10;

  // status register, busy in bit 0 and fifo count in the upper half
  typedef struct packed
  {
    logic [15:0] count;
    logic [14:0] reserved;
    logic        busy;
  } gfx_status_t;

endpackage

// File: hdl/gfx_wb_slave.sv
`include "gfx_defs.svh"

module gfx_wb_slave
(
  input  logic                     wbs_clk_i,
  input  logic                     rst_i,
  input  logic                     cs_i,
  input  logic                     cyc_i,
  input  logic                     stb_i,
  input  logic                     we_i,
  input  logic [3:0]               sel_i,
  input  logic [`GFX_ADR_W-1:0]    adr_i,
  input  logic [`GFX_DATA_W-1:0]   dat_i,
  output logic                     ack_o,
  output logic                     err_o,
  output logic [`GFX_DATA_W-1:0]   dat_o,
  output gfx_reg_pkg::gfx_reg_e    rd_adr_o,
  input  logic [`GFX_DATA_W-1:0]   rd_dat_i,
  gfx_wr_if.src                    enq
);

  import gfx_reg_pkg::*;

  logic                   acc;
  logic                   acc32;
  logic                   wr_acc;
  logic                   rd_acc;
  logic                   rd_ack_q;
  logic [`GFX_DATA_W-1:0] rd_dat_q;
  logic [`GFX_ADR_W-1:0]  word_adr;

  assign acc    = cs_i & cyc_i & stb_i;
  assign acc32  = (sel_i == 4'hF);
  assign wr_acc = acc & acc32 & we_i;
  assign rd_acc = acc & acc32 & ~we_i;

  // word aligned register address
  assign word_adr = {adr_i[`GFX_ADR_W-1:2], 2'b00};
  assign rd_adr_o = gfx_reg_e'(word_adr);

  // writes go straight into the queue
  assign enq.valid = wr_acc;
  assign enq.adr   = word_adr;
  assign enq.dat   = dat_i;

  // read ack one cycle late, guard keeps a held request to a single ack
  always_ff @(posedge wbs_clk_i)
  begin
    if (rst_i)
      rd_ack_q <= 1'b0;
    else
      rd_ack_q <= rd_acc & ~rd_ack_q;
  end

  always_ff @(posedge wbs_clk_i)
  begin
    rd_dat_q <= rd_dat_i;
  end

  // write ack is held off while the fifo is full
  assign ack_o = (wr_acc & enq.ready) | (rd_ack_q & rd_acc);
  assign err_o = acc & ~acc32;
  assign dat_o = rd_ack_q ? rd_dat_q : '0;

endmodule

// File: hdl/gfx_wbs_top.sv
`include "gfx_defs.svh"

module gfx_wbs_top
(
  input  logic                                  wbs_clk_i,
  input  logic                                  rst_i,
  input  logic                                  cs_i,
  input  logic                                  cyc_i,
  input  logic                                  stb_i,
  input  logic                                  we_i,
  input  logic [3:0]                            sel_i,
  input  logic [`GFX_ADR_W-1:0]                 adr_i,
  input  logic [`GFX_DATA_W-1:0]                dat_i,
  output logic                                  ack_o,
  output logic                                  err_o,
  output logic [`GFX_DATA_W-1:0]                dat_o,
  input  logic                                  pipeline_ack_i,
  input  logic                                  writer_sint_i,
  input  logic                                  reader_sint_i,
  output logic                                  inta_o,
  output logic [`GFX_DATA_W-1:0]                target_base_o,
  output logic [gfx_reg_pkg::POINT_W-1:0]       target_size_x_o,
  output logic [gfx_reg_pkg::POINT_W-1:0]       target_size_y_o,
  output logic [`GFX_DATA_W-1:0]                dest_x_o,
  output logic [`GFX_DATA_W-1:0]                dest_y_o,
  output logic [`GFX_DATA_W-1:0]                color0_o,
  output logic [7:0]                            global_alpha_o,
  output logic [gfx_reg_pkg::CTRL_DEPTH_W-1:0]  color_depth_o,
  output logic                                  blending_enable_o,
  output logic                                  rect_write_o,
  output logic                                  line_write_o,
  output logic                                  point_write_o
);

  import gfx_reg_pkg::*;
  import gfx_ctrl_pkg::*;

  gfx_reg_e               rd_adr;
  logic [`GFX_DATA_W-1:0] rd_dat;
  logic [`GFX_FIFO_AW:0]  fifo_count;
  logic                   cmd_active;
  logic                   busy;
  logic                   drain_ready;
  gfx_draw_cmd_e          draw_cmd;

  gfx_wr_if enq_if ();
  gfx_wr_if deq_if ();

  // drain permission
  assign deq_if.ready = drain_ready;

  gfx_wb_slave u_wb_slave
  (
    .wbs_clk_i (wbs_clk_i),
    .rst_i     (rst_i),
    .cs_i      (cs_i),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .sel_i     (sel_i),
    .adr_i     (adr_i),
    .dat_i     (dat_i),
    .ack_o     (ack_o),
    .err_o     (err_o),
    .dat_o     (dat_o),
    .rd_adr_o  (rd_adr),
    .rd_dat_i  (rd_dat),
    .enq       (enq_if.src)
  );

  gfx_instr_fifo #(.ADDR_W(`GFX_FIFO_AW)) u_instr_fifo
  (
    .wbs_clk_i (wbs_clk_i),
    .rst_i     (rst_i),
    .enq       (enq_if.snk),
    .deq       (deq_if.src),
    .count_o   (fifo_count)
  );

  gfx_reg_file u_reg_file
  (
    .wbs_clk_i         (wbs_clk_i),
    .rst_i             (rst_i),
    .deq               (deq_if.snk),
    .rd_adr_i          (rd_adr),
    .rd_dat_o          (rd_dat),
    .busy_i            (busy),
    .fifo_count_i      (fifo_count),
    .cmd_active_o      (cmd_active),
    .draw_cmd_o        (draw_cmd),
    .target_base_o     (target_base_o),
    .target_size_x_o   (target_size_x_o),
    .target_size_y_o   (target_size_y_o),
    .dest_x_o          (dest_x_o),
    .dest_y_o          (dest_y_o),
    .color0_o          (color0_o),
    .global_alpha_o    (global_alpha_o),
    .color_depth_o     (color_depth_o),
    .blending_enable_o (blending_enable_o)
  );

  gfx_cmd_sequencer u_cmd_sequencer
  (
    .wbs_clk_i      (wbs_clk_i),
    .rst_i          (rst_i),
    .draw_cmd_i     (draw_cmd),
    .cmd_active_i   (cmd_active),
    .pipeline_ack_i (pipeline_ack_i),
    .drain_ready_o  (drain_ready),
    .busy_o         (busy),
    .writer_sint_i  (writer_sint_i),
    .reader_sint_i  (reader_sint_i),
    .inta_o         (inta_o)
  );

  // one-hot draw strobes for the pipeline
  assign rect_write_o  = (draw_cmd == RECT);
  assign line_write_o  = (draw_cmd == LINE);
  assign point_write_o = (draw_cmd == POINT);

endmodule

// File: hdl/gfx_wr_if.sv
`include "gfx_defs.svh"

interface gfx_wr_if;

  logic                   valid;
  logic                   ready;
  logic [`GFX_ADR_W-1:0]  adr;
  logic [`GFX_DATA_W-1:0] dat;

  // an item moves on every cycle with valid and ready both high
  modport src
  (
    output valid,
    output adr,
    output dat,
    input  ready
  );

  modport snk
  (
    input  valid,
    input  adr,
    input  dat,
    output ready
  );

endinterface

// File: testbench/tb_gfx_wbs.sv
`include "gfx_defs.svh"

module tb_gfx_wbs;

  timeunit 1ns;
  timeprecision 100ps;

  import gfx_reg_pkg::*;

  localparam int ACC_LIMIT    = 64;
  localparam int SETTLE_LIMIT = 200;
  // the whole run takes about a thousand cycles
  localparam int WATCHDOG_CYCLES = 20000;
  localparam logic [31:0] DRAW_MASK = 32'h0000_0700;

  logic                    wbs_clk_i;
  logic                    rst_i;
  logic                    cs_i;
  logic                    cyc_i;
  logic                    stb_i;
  logic                    we_i;
  logic [3:0]              sel_i;
  logic [`GFX_ADR_W-1:0]   adr_i;
  logic [`GFX_DATA_W-1:0]  dat_i;
  logic                    ack_o;
  logic                    err_o;
  logic [`GFX_DATA_W-1:0]  dat_o;
  logic                    pipeline_ack_i;
  logic                    writer_sint_i;
  logic                    reader_sint_i;
  logic                    inta_o;
  logic [31:0]             target_base_o;
  logic [15:0]             target_size_x_o;
  logic [15:0]             target_size_y_o;
  logic [31:0]             dest_x_o;
  logic [31:0]             dest_y_o;
  logic [31:0]             color0_o;
  logic [7:0]              global_alpha_o;
  logic [1:0]              color_depth_o;
  logic                    blending_enable_o;
  logic                    rect_write_o;
  logic                    line_write_o;
  logic                    point_write_o;

  // register model, indexed by word address
  logic [31:0] model_regs [64];
  logic        model_busy;
  logic [7:0]  pend_adr [$];
  logic [31:0] pend_dat [$];

  string       chk_name [$];
  logic [31:0] chk_exp [$];
  logic [31:0] chk_act [$];
  event        chk_ev;
  int          err_count;
  int          check_count;
  int          test_count;
  int          test_fail_count;
  int          test_err_start;
  string       test_name;
  // cycles seen high on rect, line and point
  int          draw_cnt [3];

  gfx_wbs_top uut
  (
    .wbs_clk_i         (wbs_clk_i),
    .rst_i             (rst_i),
    .cs_i              (cs_i),
    .cyc_i             (cyc_i),
    .stb_i             (stb_i),
    .we_i              (we_i),
    .sel_i             (sel_i),
    .adr_i             (adr_i),
    .dat_i             (dat_i),
    .ack_o             (ack_o),
    .err_o             (err_o),
    .dat_o             (dat_o),
    .pipeline_ack_i    (pipeline_ack_i),
    .writer_sint_i     (writer_sint_i),
    .reader_sint_i     (reader_sint_i),
    .inta_o            (inta_o),
    .target_base_o     (target_base_o),
    .target_size_x_o   (target_size_x_o),
    .target_size_y_o   (target_size_y_o),
    .dest_x_o          (dest_x_o),
    .dest_y_o          (dest_y_o),
    .color0_o          (color0_o),
    .global_alpha_o    (global_alpha_o),
    .color_depth_o     (color_depth_o),
    .blending_enable_o (blending_enable_o),
    .rect_write_o      (rect_write_o),
    .line_write_o      (line_write_o),
    .point_write_o     (point_write_o)
  );

  initial wbs_clk_i = 1'b0;
  always #4 wbs_clk_i = ~wbs_clk_i;

  always @(negedge wbs_clk_i)
  begin
    if (rect_write_o)
      draw_cnt[0]++;
    if (line_write_o)
      draw_cnt[1]++;
    if (point_write_o)
      draw_cnt[2]++;
  end

  // compare process, drains whatever checks are queued
  always
  begin : compare_proc
    string       name;
    logic [31:0] exp_v;
    logic [31:0] act_v;
    @(chk_ev);
    while (chk_act.size() > 0)
    begin
      name  = chk_name.pop_front();
      exp_v = chk_exp.pop_front();
      act_v = chk_act.pop_front();
      check_count++;
      assert (act_v === exp_v)
      else
      begin
        $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
        err_count++;
      end
    end
  end

  function automatic void model_reset();
    for (int i = 0; i < 64; i++)
      model_regs[i] = '0;
    model_regs[0] = `GFX_CTRL_RESET;
    model_regs[8] = `GFX_ALPHA_RESET;
    model_busy = 1'b0;
    pend_adr.delete();
    pend_dat.delete();
  endfunction

  // status and unmapped addresses keep nothing
  function automatic void model_write(input logic [7:0] adr, input logic [31:0] dat);
    if (adr == STATUS || adr > ALPHA)
      return;
    model_regs[adr[7:2]] = (adr == CONTROL) ? (dat & ~DRAW_MASK) : dat;
  endfunction

  function automatic void apply_pending();
    while (pend_adr.size() > 0)
      model_write(pend_adr.pop_front(), pend_dat.pop_front());
  endfunction

  function automatic logic [31:0] ref_read(input logic [7:0] adr);
    if (adr == STATUS)
      return {16'(pend_adr.size()), 15'd0, model_busy};
    return model_regs[adr[7:2]];
  endfunction

  function automatic string draw_name(input int k);
    case (k)
      0:       return "rect_write_o";
      1:       return "line_write_o";
      default: return "point_write_o";
    endcase
  endfunction

  task automatic expect_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    chk_name.push_back(name);
    chk_exp.push_back(exp_v);
    chk_act.push_back(act_v);
    -> chk_ev;
  endtask

  // one access, ends on ack or err
  task automatic bus_access(input logic we, input logic [3:0] sel, input logic [7:0] adr,
                            input logic [31:0] dat, output logic got_ack,
                            output logic got_err, output logic [31:0] rdata);
    int n;
    got_ack = 1'b0;
    got_err = 1'b0;
    rdata   = '0;
    n       = 0;
    @(posedge wbs_clk_i);
    #1;
    cs_i  = 1'b1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    sel_i = sel;
    adr_i = adr;
    dat_i = dat;
    while (!got_ack && !got_err && n < ACC_LIMIT)
    begin
      @(negedge wbs_clk_i);
      got_ack = ack_o;
      got_err = err_o;
      rdata   = dat_o;
      n++;
    end
    @(posedge wbs_clk_i);
    #1;
    cs_i  = 1'b0;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat);
    logic        ack;
    logic        err;
    logic [31:0] rd;
    bus_access(1'b1, 4'hF, adr, dat, ack, err, rd);
    assert (ack)
    else
    begin
      $display("write to address %h was never acknowledged", adr);
      err_count++;
    end
    if (ack)
    begin
      pend_adr.push_back(adr);
      pend_dat.push_back(dat);
    end
  endtask

  task automatic read_reg(input logic [7:0] adr, output logic [31:0] data);
    logic ack;
    logic err;
    bus_access(1'b0, 4'hF, adr, 32'd0, ack, err, data);
    assert (ack)
    else
    begin
      $display("read of address %h was never acknowledged", adr);
      err_count++;
    end
  endtask

  task automatic read_and_compare(input logic [7:0] adr);
    logic [31:0] rd;
    gfx_reg_e    reg_id;
    reg_id = gfx_reg_e'(adr);
    read_reg(adr, rd);
    expect_value($sformatf("%s@%02h", reg_id.name(), adr), ref_read(adr), rd);
  endtask

  task automatic read_all_regs();
    for (int a = 0; a < 10; a++)
      read_and_compare(8'(a * 4));
  endtask

  task automatic compare_outputs();
    expect_value("target_base_o", model_regs[6'd2], target_base_o);
    expect_value("target_size_x_o", {16'd0, model_regs[6'd3][15:0]}, {16'd0, target_size_x_o});
    expect_value("target_size_y_o", {16'd0, model_regs[6'd4][15:0]}, {16'd0, target_size_y_o});
    expect_value("dest_x_o", model_regs[6'd5], dest_x_o);
    expect_value("dest_y_o", model_regs[6'd6], dest_y_o);
    expect_value("color0_o", model_regs[6'd7], color0_o);
    expect_value("global_alpha_o", {24'd0, model_regs[6'd8][7:0]}, {24'd0, global_alpha_o});
    expect_value("color_depth_o", {30'd0, model_regs[6'd0][1:0]}, {30'd0, color_depth_o});
    expect_value("blending_enable_o", {31'd0, model_regs[6'd0][2]}, {31'd0, blending_enable_o});
  endtask

  // poll status until the queue is empty, then the model catches up
  task automatic wait_fifo_empty();
    logic [31:0] st;
    int          n;
    st = 32'hffff_ffff;
    n  = 0;
    while (st[31:16] != 16'd0 && n < SETTLE_LIMIT)
    begin
      read_reg(STATUS, st);
      n++;
    end
    assert (st[31:16] == 16'd0)
    else
    begin
      $display("instruction FIFO did not drain within %0d status reads", SETTLE_LIMIT);
      err_count++;
    end
    apply_pending();
  endtask

  task automatic pulse_pipeline_ack();
    @(posedge wbs_clk_i);
    #1;
    pipeline_ack_i = 1'b1;
    @(posedge wbs_clk_i);
    #1;
    pipeline_ack_i = 1'b0;
    model_busy = 1'b0;
  endtask

  task automatic pulse_sint(input logic wr, input logic rd);
    @(posedge wbs_clk_i);
    #1;
    writer_sint_i = wr;
    reader_sint_i = rd;
    @(negedge wbs_clk_i);
    expect_value("inta_o same cycle", 32'd0, {31'd0, inta_o});
    @(posedge wbs_clk_i);
    #1;
    writer_sint_i = 1'b0;
    reader_sint_i = 1'b0;
    @(negedge wbs_clk_i);
    expect_value("inta_o next cycle", 32'd1, {31'd0, inta_o});
    @(negedge wbs_clk_i);
    expect_value("inta_o after release", 32'd0, {31'd0, inta_o});
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_count;
  endtask

  task automatic finish_test();
    int errs;
    @(posedge wbs_clk_i);
    errs = err_count - test_err_start;
    test_count++;
    if (errs == 0)
      $display("test %s: ok", test_name);
    else
    begin
      test_fail_count++;
      $display("test %s: FAILED with %0d errors", test_name, errs);
    end
  endtask

  task automatic reset_values();
    expect_value("ack_o", 32'd0, {31'd0, ack_o});
    expect_value("err_o", 32'd0, {31'd0, err_o});
    expect_value("inta_o", 32'd0, {31'd0, inta_o});
    expect_value("draw outputs", 32'd0, {29'd0, rect_write_o, line_write_o, point_write_o});
    read_all_regs();
    compare_outputs();
  endtask

  task automatic write_read_back();
    logic [31:0] d;
    // status is written too and must stay untouched
    for (int a = 0; a < 9; a++)
    begin
      d = $urandom();
      if (a == 0)
        d = d & ~DRAW_MASK;
      write_reg(8'(a * 4), d);
    end
    wait_fifo_empty();
    read_all_regs();
    compare_outputs();
  endtask

  task automatic partial_select();
    logic        ack;
    logic        err;
    logic [31:0] rd;
    bus_access(1'b1, 4'h3, COLOR0, $urandom(), ack, err, rd);
    assert (err && !ack)
    else
    begin
      $display("partial write to COLOR0 did not end with err_o alone");
      err_count++;
    end
    bus_access(1'b0, 4'hC, COLOR0, 32'd0, ack, err, rd);
    assert (err && !ack)
    else
    begin
      $display("partial read of COLOR0 did not end with err_o alone");
      err_count++;
    end
    read_and_compare(STATUS);
    read_and_compare(COLOR0);
  endtask

  task automatic draw_commands(input int k);
    int          start [3];
    int          n;
    logic [31:0] d;
    d     = ($urandom() & ~DRAW_MASK) | (32'h100 << k);
    start = draw_cnt;
    n     = 0;
    write_reg(CONTROL, d);
    while (draw_cnt[k] == start[k] && n < ACC_LIMIT)
    begin
      @(posedge wbs_clk_i);
      n++;
    end
    repeat (3) @(posedge wbs_clk_i);
    #1;
    for (int i = 0; i < 3; i++)
      expect_value($sformatf("%s high cycles", draw_name(i)), (i == k) ? 1 : 0,
                   draw_cnt[i] - start[i]);
    // control write has landed, pipeline now owns the command
    apply_pending();
    model_busy = 1'b1;
    read_and_compare(STATUS);
    read_and_compare(CONTROL);
    // dest x twice so the order of landing shows
    write_reg(DEST_X, $urandom());
    write_reg(COLOR0, $urandom());
    write_reg(DEST_X, $urandom());
    read_and_compare(STATUS);
    compare_outputs();
    pulse_pipeline_ack();
    wait_fifo_empty();
    read_all_regs();
    compare_outputs();
  endtask

  task automatic back_pressure();
    logic [31:0] d;
    d = ($urandom() & ~DRAW_MASK) | 32'h100;
    write_reg(CONTROL, d);
    wait_fifo_empty();
    model_busy = 1'b1;
    for (int i = 0; i < 16; i++)
      write_reg(8'(8 + (i % 4) * 4), $urandom());
    read_and_compare(STATUS);
    fork
      write_reg(COLOR0, $urandom());
      begin
        repeat (6)
        begin
          @(negedge wbs_clk_i);
          assert (!ack_o)
          else
          begin
            $display("write to a full FIFO was acknowledged at %0t", $time);
            err_count++;
          end
        end
        pulse_pipeline_ack();
      end
    join
    wait_fifo_empty();
    read_all_regs();
    compare_outputs();
  endtask

  task automatic interrupt_output();
    pulse_sint(1'b1, 1'b0);
    pulse_sint(1'b0, 1'b1);
    pulse_sint(1'b1, 1'b1);
  endtask

  initial
  begin
    void'($urandom(42048));
    rst_i          = 1'b1;
    cs_i           = 1'b0;
    cyc_i          = 1'b0;
    stb_i          = 1'b0;
    we_i           = 1'b0;
    sel_i          = 4'h0;
    adr_i          = '0;
    dat_i          = '0;
    pipeline_ack_i = 1'b0;
    writer_sint_i  = 1'b0;
    reader_sint_i  = 1'b0;
    model_reset();
    repeat (10) @(posedge wbs_clk_i);
    #1;
    rst_i = 1'b0;

    start_test("reset values");
    reset_values();
    finish_test();
    start_test("write and read back");
    write_read_back();
    finish_test();
    start_test("partial select");
    partial_select();
    finish_test();
    for (int k = 0; k < 3; k++)
    begin
      start_test($sformatf("draw command %s", draw_name(k)));
      draw_commands(k);
      finish_test();
    end
    start_test("back-pressure");
    back_pressure();
    finish_test();
    start_test("interrupt");
    interrupt_output();
    finish_test();

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_count, test_fail_count, check_count, err_count);
    if (err_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge wbs_clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule
